//--- common/rw_ctrl_pkg.sv
`default_nettype none

`include "rw_defs.svh"

package rw_ctrl_pkg;

    // --------------------
    // Run configuration
    // --------------------

    // 86 bits in total
    typedef struct packed {
        logic [`RW_ADDR_W-1:0]  base_address;
        logic [4:0]             index_shift;
        logic [`RW_COUNT_W-1:0] item_count;
        logic                   mode_write;
        logic [`RW_DATA_W-1:0]  write_mask;
    } rw_config_t;

    // --------------------
    // Generator FSM
    // --------------------
    typedef enum logic [2:0] {
        GEN_RESET,
        GEN_IDLE,
        GEN_SETUP_REQUEST,
        GEN_SETUP_WAIT,
        GEN_BUSY,
        GEN_DRAIN,
        GEN_DONE
    } gen_state_t;

endpackage

`default_nettype wire

//--- common/rw_defs.svh
`ifndef RW_DEFS_SVH
`define RW_DEFS_SVH

// --------------------
// Datapath widths
// --------------------

// Memory address and data word
`define RW_ADDR_W 32
`define RW_DATA_W 32

// Engine item index
`define RW_INDEX_W 16

// Item and outstanding-read counters
`define RW_COUNT_W 16

// --------------------
// FIFO sizing
// --------------------

// Entries per FIFO as a power of two
`define RW_FIFO_DEPTH 16

// Occupancy at which prog_full rises
`define RW_PROG_THRESH 8

`endif

//--- common/rw_mem_pkg.sv
`default_nettype none

`include "rw_defs.svh"

package rw_mem_pkg;

    // --------------------
    // Memory command
    // --------------------
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_cmd_t;

    // --------------------
    // Engine side item
    // --------------------

    // One 48-bit unit of work from the engine
    typedef struct packed {
        logic [`RW_INDEX_W-1:0] index;
        logic [`RW_DATA_W-1:0]  value;
    } engine_item_t;

    // --------------------
    // Memory side request
    // --------------------

    // Address, data and command in 65 bits
    typedef struct packed {
        logic [`RW_ADDR_W-1:0] address;
        logic [`RW_DATA_W-1:0] data;
        mem_cmd_t              cmd;
    } mem_request_t;

endpackage

`default_nettype wire

//--- generator/engine_read_write_generator.sv
`default_nettype none

`include "rw_defs.svh"

module engine_read_write_generator
    import rw_mem_pkg::*;
    import rw_ctrl_pkg::*;
(
    input  wire logic                   ap_clk,
    input  wire logic                   areset,
    input  wire logic                   start,
    input  wire logic                   config_valid,
    input  wire rw_config_t             config_data,
    input  wire logic                   engine_valid,
    input  wire logic [`RW_INDEX_W-1:0] engine_index,
    input  wire logic [`RW_DATA_W-1:0]  engine_value,
    input  wire logic                   mem_ready,
    input  wire logic                   mem_resp_valid,
    input  wire logic [`RW_DATA_W-1:0]  mem_resp_data,
    output logic                        config_request,
    output logic                        engine_full,
    output logic                        mem_req_valid,
    output logic [`RW_ADDR_W-1:0]       mem_req_address,
    output logic [`RW_DATA_W-1:0]       mem_req_data,
    output logic                        mem_req_write,
    output logic                        engine_resp_valid,
    output logic [`RW_DATA_W-1:0]       engine_resp_data,
    output logic                        done
);

    logic areset_generator;

    engine_item_t engine_item;
    engine_item_t in_pop_data;
    logic         in_pop;
    logic         in_pop_valid;
    logic         in_empty;

    mem_request_t kernel_request;
    logic         kernel_request_valid;
    logic         kernel_busy;
    logic         kernel_enable;

    mem_request_t req_pop_data;
    logic         req_pop;
    logic         req_pop_valid;
    logic         req_empty;
    logic         req_prog_full;

    rw_config_t active_config;
    logic       pipeline_idle;
    logic       outstanding_zero;

    // --------------------
    // Reset register
    // --------------------
    always_ff @(posedge ap_clk) begin
        areset_generator <= areset;
    end

    // --------------------
    // Input side
    // --------------------
    assign engine_item.index = engine_index;
    assign engine_item.value = engine_value;

    // Kernel pulls only while the run wants items and requests have room
    assign in_pop = kernel_enable & ~in_empty & ~req_prog_full;

    sync_fifo #(
        .payload_t(engine_item_t)
    ) u_input_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (engine_valid),
        .push_data       (engine_item),
        .pop             (in_pop),
        .pop_data        (in_pop_data),
        .pop_valid       (in_pop_valid),
        .empty           (in_empty),
        .prog_full       (engine_full)
    );

    rw_address_kernel u_rw_address_kernel (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .item_valid      (in_pop_valid),
        .item            (in_pop_data),
        .active_config   (active_config),
        .request_valid   (kernel_request_valid),
        .request         (kernel_request),
        .busy            (kernel_busy)
    );

    // --------------------
    // Memory request side
    // --------------------
    assign req_pop = mem_ready & ~req_empty;

    sync_fifo #(
        .payload_t(mem_request_t)
    ) u_request_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (kernel_request_valid),
        .push_data       (kernel_request),
        .pop             (req_pop),
        .pop_data        (req_pop_data),
        .pop_valid       (req_pop_valid),
        .empty           (req_empty),
        .prog_full       (req_prog_full)
    );

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            mem_req_valid <= 1'b0;
        end else begin
            mem_req_valid <= req_pop_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        mem_req_address <= req_pop_data.address;
        mem_req_data    <= req_pop_data.data;
        mem_req_write   <= (req_pop_data.cmd == MEM_WRITE);
    end

    memory_response_path u_memory_response_path (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .mem_resp_valid   (mem_resp_valid),
        .mem_resp_data    (mem_resp_data),
        .read_issued      (mem_req_valid & ~mem_req_write),
        .engine_resp_valid(engine_resp_valid),
        .engine_resp_data (engine_resp_data),
        .outstanding_zero (outstanding_zero)
    );

    // --------------------
    // Run control
    // --------------------

    // FIFO read registers count as in flight too
    assign pipeline_idle = in_empty & ~in_pop_valid & req_empty & ~req_pop_valid
                         & ~kernel_busy & ~mem_req_valid;

    rw_control_fsm u_rw_control_fsm (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .start           (start),
        .config_valid    (config_valid),
        .config_data     (config_data),
        .item_popped     (in_pop),
        .pipeline_idle   (pipeline_idle),
        .outstanding_zero(outstanding_zero),
        .config_request  (config_request),
        .kernel_enable   (kernel_enable),
        .active_config   (active_config),
        .done            (done)
    );

endmodule

`default_nettype wire

//--- generator/memory_response_path.sv
`default_nettype none

`include "rw_defs.svh"

module memory_response_path (
    input  wire logic                  ap_clk,
    input  wire logic                  areset_generator,
    input  wire logic                  mem_resp_valid,
    input  wire logic [`RW_DATA_W-1:0] mem_resp_data,
    input  wire logic                  read_issued,
    output logic                       engine_resp_valid,
    output logic [`RW_DATA_W-1:0]      engine_resp_data,
    output logic                       outstanding_zero
);

    logic                   s1_valid;
    logic [`RW_DATA_W-1:0]  s1_data;
    logic [`RW_COUNT_W-1:0] outstanding;

    assign outstanding_zero = (outstanding == '0);

    // --------------------
    // Response forwarding
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid          <= 1'b0;
            engine_resp_valid <= 1'b0;
        end else begin
            s1_valid          <= mem_resp_valid;
            engine_resp_valid <= s1_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        s1_data          <= mem_resp_data;
        engine_resp_data <= s1_data;
    end

    // Reads in memory are counted at issue and at delivery
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            outstanding <= '0;
        end else if (read_issued && !engine_resp_valid) begin
            outstanding <= outstanding + 1'b1;
        end else if (engine_resp_valid && !read_issued) begin
            outstanding <= outstanding - 1'b1;
        end
    end

    // A response with nothing outstanding means memory answered twice
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        !(engine_resp_valid && !read_issued && outstanding_zero));

endmodule

`default_nettype wire

//--- generator/rw_address_kernel.sv
`default_nettype none

`include "rw_defs.svh"

module rw_address_kernel
    import rw_mem_pkg::*;
    import rw_ctrl_pkg::*;
(
    input  wire logic         ap_clk,
    input  wire logic         areset_generator,
    input  wire logic         item_valid,
    input  wire engine_item_t item,
    input  wire rw_config_t   active_config,
    output logic              request_valid,
    output mem_request_t      request,
    output logic              busy
);

    logic                  s1_valid;
    logic [`RW_ADDR_W-1:0] s1_offset;
    logic [`RW_DATA_W-1:0] s1_data;
    logic [`RW_ADDR_W-1:0] index_wide;

    assign index_wide = {{(`RW_ADDR_W - `RW_INDEX_W){1'b0}}, item.index};

    assign busy = s1_valid | request_valid;

    // --------------------
    // Valid pipe
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid      <= 1'b0;
            request_valid <= 1'b0;
        end else begin
            s1_valid      <= item_valid;
            request_valid <= s1_valid;
        end
    end

    // Stage one shifts the index and masks the value
    always_ff @(posedge ap_clk) begin
        s1_offset <= index_wide << active_config.index_shift;
        s1_data   <= item.value ^ active_config.write_mask;
    end

    // Stage two adds the base and picks the command
    always_ff @(posedge ap_clk) begin
        request.address <= active_config.base_address + s1_offset;
        request.data    <= s1_data;
        request.cmd     <= active_config.mode_write ? MEM_WRITE : MEM_READ;
    end

endmodule

`default_nettype wire

//--- generator/rw_control_fsm.sv
`default_nettype none

`include "rw_defs.svh"

module rw_control_fsm
    import rw_ctrl_pkg::*;
(
    input  wire logic       ap_clk,
    input  wire logic       areset_generator,
    input  wire logic       start,
    input  wire logic       config_valid,
    input  wire rw_config_t config_data,
    input  wire logic       item_popped,
    input  wire logic       pipeline_idle,
    input  wire logic       outstanding_zero,
    output logic            config_request,
    output logic            kernel_enable,
    output rw_config_t      active_config,
    output logic            done
);

    gen_state_t current_state;
    gen_state_t next_state;

    logic [`RW_COUNT_W-1:0] items_popped;
    logic                   all_popped;
    logic                   config_accept;

    // Config is taken only once the request pulse is over
    assign config_accept = (current_state == GEN_SETUP_WAIT) & config_valid & ~config_request;
    assign all_popped    = (items_popped == active_config.item_count);

    assign kernel_enable = (current_state == GEN_BUSY) & ~all_popped;
    assign done          = (current_state == GEN_DONE);

    // --------------------
    // State register
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            current_state <= GEN_RESET;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            GEN_RESET: begin
                next_state = GEN_IDLE;
            end
            GEN_IDLE, GEN_DONE: begin
                if (start) begin
                    next_state = GEN_SETUP_REQUEST;
                end
            end
            GEN_SETUP_REQUEST: begin
                next_state = GEN_SETUP_WAIT;
            end
            GEN_SETUP_WAIT: begin
                if (config_accept) begin
                    next_state = GEN_BUSY;
                end
            end
            GEN_BUSY: begin
                if (all_popped) begin
                    next_state = GEN_DRAIN;
                end
            end
            GEN_DRAIN: begin
                if (pipeline_idle && outstanding_zero) begin
                    next_state = GEN_DONE;
                end
            end
            default: begin
                next_state = GEN_RESET;
            end
        endcase
    end

    // --------------------
    // Request pulse and item count
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            config_request <= 1'b0;
            items_popped   <= '0;
        end else begin
            config_request <= (current_state == GEN_SETUP_REQUEST);
            if (config_accept) begin
                items_popped <= '0;
            end else if (item_popped) begin
                items_popped <= items_popped + 1'b1;
            end
        end
    end

    always_ff @(posedge ap_clk) begin
        if (config_accept) begin
            active_config <= config_data;
        end
    end

    // No read may still be in memory once done is up
    assert property (@(posedge ap_clk) disable iff (areset_generator) done |-> outstanding_zero);

endmodule

`default_nettype wire

//--- logic/sync_fifo.sv
`default_nettype none

`include "rw_defs.svh"

module sync_fifo #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic     ap_clk,
    input  wire logic     areset_generator,
    input  wire logic     push,
    input  wire payload_t push_data,
    input  wire logic     pop,
    output payload_t      pop_data,
    output logic          pop_valid,
    output logic          empty,
    output logic          prog_full
);

    localparam int PTR_W = $clog2(`RW_FIFO_DEPTH);
    localparam int CNT_W = $clog2(`RW_FIFO_DEPTH + 1);

    payload_t mem [`RW_FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_push;
    logic             do_pop;

    assign full      = (count == CNT_W'(`RW_FIFO_DEPTH));
    assign empty     = (count == '0);
    assign prog_full = (count >= CNT_W'(`RW_PROG_THRESH));

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    // --------------------
    // Pointers and occupancy
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            pop_valid <= 1'b0;
        end else begin
            pop_valid <= do_pop;
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Storage and registered read port
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
        if (do_pop) begin
            pop_data <= mem[rd_ptr];
        end
    end

    // Producers must respect full and consumers must respect empty
    assert property (@(posedge ap_clk) disable iff (areset_generator) !(push && full));
    assert property (@(posedge ap_clk) disable iff (areset_generator) !(pop && empty));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, then search the log for failure
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f src.f \
    --top-module tb_engine_read_write_generator \
    -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "ERRORS FOUND" sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"

//--- src.f
+incdir+common
common/rw_mem_pkg.sv
common/rw_ctrl_pkg.sv
logic/sync_fifo.sv
generator/rw_control_fsm.sv
generator/rw_address_kernel.sv
generator/memory_response_path.sv
generator/engine_read_write_generator.sv
tests/tb_engine_read_write_generator.sv

//--- tests/tb_engine_read_write_generator.sv
`default_nettype none

`include "rw_defs.svh"

module tb_engine_read_write_generator
    import rw_mem_pkg::*;
    import rw_ctrl_pkg::*;
();

    localparam int CHECK_W = 65;
    localparam int COUNT_W = `RW_COUNT_W;
    localparam logic [31:0] SEED = 32'hae874b78;
    localparam logic [`RW_DATA_W-1:0] RESP_XOR = 32'hc3a5_5a3c;

    localparam int READ_ITEMS = 20;
    localparam int WRITE_ITEMS = 16;
    localparam int BURST_ITEMS = 40;
    localparam int RECONF_ITEMS = 12;
    localparam int TOTAL_ITEMS = READ_ITEMS + WRITE_ITEMS + BURST_ITEMS + RECONF_ITEMS;
    localparam int WATCHDOG_CYCLES = TOTAL_ITEMS * 50 + 2000;

    logic                   ap_clk = 1'b0;
    logic                   areset;
    logic                   start;
    logic                   config_valid;
    rw_config_t             config_data;
    logic                   engine_valid;
    logic [`RW_INDEX_W-1:0] engine_index;
    logic [`RW_DATA_W-1:0]  engine_value;
    logic                   mem_ready = 1'b0;
    logic                   mem_resp_valid = 1'b0;
    logic [`RW_DATA_W-1:0]  mem_resp_data = '0;
    logic                   config_request;
    logic                   engine_full;
    logic                   mem_req_valid;
    logic [`RW_ADDR_W-1:0]  mem_req_address;
    logic [`RW_DATA_W-1:0]  mem_req_data;
    logic                   mem_req_write;
    logic                   engine_resp_valid;
    logic [`RW_DATA_W-1:0]  engine_resp_data;
    logic                   done;

    integer seed = SEED;
    int     error_count = 0;
    int     check_count = 0;
    int     reads_seen = 0;
    int     resps_seen = 0;
    int     resp_wait = 0;
    logic   ready_random = 1'b0;
    string  test_name = "reset";

    mem_request_t          exp_req[$];
    logic [`RW_ADDR_W-1:0] read_pending[$];
    logic [`RW_DATA_W-1:0] resp_exp[$];

    always #5 ap_clk = ~ap_clk;

    engine_read_write_generator u_engine_read_write_generator (
        .ap_clk           (ap_clk),
        .areset           (areset),
        .start            (start),
        .config_valid     (config_valid),
        .config_data      (config_data),
        .engine_valid     (engine_valid),
        .engine_index     (engine_index),
        .engine_value     (engine_value),
        .mem_ready        (mem_ready),
        .mem_resp_valid   (mem_resp_valid),
        .mem_resp_data    (mem_resp_data),
        .config_request   (config_request),
        .engine_full      (engine_full),
        .mem_req_valid    (mem_req_valid),
        .mem_req_address  (mem_req_address),
        .mem_req_data     (mem_req_data),
        .mem_req_write    (mem_req_write),
        .engine_resp_valid(engine_resp_valid),
        .engine_resp_data (engine_resp_data),
        .done             (done)
    );

    // --------------------
    // Reference and check
    // --------------------

    // Address is base plus shifted index and data is value XOR mask
    function automatic mem_request_t expected_request(input logic [`RW_INDEX_W-1:0] index,
                                                      input logic [`RW_DATA_W-1:0] value,
                                                      input rw_config_t cfg);
        mem_request_t          req;
        logic [`RW_ADDR_W-1:0] offset;
        offset      = {{(`RW_ADDR_W - `RW_INDEX_W){1'b0}}, index};
        offset      = offset << cfg.index_shift;
        req.address = cfg.base_address + offset;
        req.data    = value ^ cfg.write_mask;
        req.cmd     = cfg.mode_write ? MEM_WRITE : MEM_READ;
        return req;
    endfunction

    task automatic check_value(input string name, input logic [CHECK_W-1:0] expected,
                               input logic [CHECK_W-1:0] actual);
        check_count = check_count + 1;
        if (expected !== actual) begin
            error_count = error_count + 1;
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // --------------------
    // Memory model and monitors
    // --------------------
    always @(negedge ap_clk) begin
        mem_request_t          req_item;
        logic [`RW_ADDR_W-1:0] addr;
        logic [`RW_DATA_W-1:0] exp_data;
        logic [31:0]           rnd;

        // Requests in push order
        if (mem_req_valid) begin
            if (exp_req.size() == 0) begin
                error_count = error_count + 1;
                $display("%s: memory request to %h with no item pending", test_name,
                         mem_req_address);
            end else begin
                req_item = exp_req.pop_front();
                check_value({test_name, ": request"}, req_item,
                            {mem_req_address, mem_req_data, mem_req_write});
            end
            if (!mem_req_write) begin
                read_pending.push_back(mem_req_address);
                reads_seen = reads_seen + 1;
            end
        end

        // Responses come back unchanged and in order
        if (engine_resp_valid) begin
            resps_seen = resps_seen + 1;
            if (resp_exp.size() == 0) begin
                error_count = error_count + 1;
                $display("%s: engine response with no read answered", test_name);
            end else begin
                exp_data = resp_exp.pop_front();
                check_value({test_name, ": response data"}, CHECK_W'(exp_data),
                            CHECK_W'(engine_resp_data));
            end
        end

        if (done && (read_pending.size() != 0 || resp_exp.size() != 0)) begin
            error_count = error_count + 1;
            $display("%s: done is high while reads are still unanswered", test_name);
        end

        // One response at a time after a short random wait
        mem_resp_valid = 1'b0;
        if (resp_wait > 0) begin
            resp_wait = resp_wait - 1;
        end else if (read_pending.size() != 0) begin
            addr           = read_pending.pop_front();
            mem_resp_valid = 1'b1;
            mem_resp_data  = addr ^ RESP_XOR;
            resp_exp.push_back(addr ^ RESP_XOR);
            rnd            = $random(seed);
            resp_wait      = int'(rnd[1:0]);
        end

        // Ready about one cycle in four so both FIFOs fill up
        if (ready_random) begin
            rnd       = $random(seed);
            mem_ready = (rnd[1:0] == 2'b00);
        end else begin
            mem_ready = 1'b1;
        end
    end

    // --------------------
    // One run from start to done
    // --------------------
    task automatic run_test(input string name, input logic [31:0] base, input logic [4:0] shift,
                            input int count, input logic write, input logic [31:0] mask,
                            input logic bursty);
        rw_config_t  cfg;
        int          cycles;
        int          pushed;
        int          pause;
        int          reads_before;
        int          resps_before;
        int          expected_reads;
        logic [31:0] rnd;

        cfg.base_address = base;
        cfg.index_shift  = shift;
        cfg.item_count   = COUNT_W'(count);
        cfg.mode_write   = write;
        cfg.write_mask   = mask;
        expected_reads   = write ? 0 : count;
        test_name        = name;
        ready_random     = bursty;
        reads_before     = reads_seen;
        resps_before     = resps_seen;

        @(negedge ap_clk);
        start = 1'b1;
        @(negedge ap_clk);
        start  = 1'b0;
        cycles = 1;
        while (!config_request) begin
            @(negedge ap_clk);
            cycles = cycles + 1;
        end
        check_value({name, ": config_request delay"}, CHECK_W'(2), CHECK_W'(cycles));

        // Configuration goes in once the pulse is over
        @(negedge ap_clk);
        check_value({name, ": config_request pulse"}, CHECK_W'(0), CHECK_W'(config_request));
        config_valid = 1'b1;
        config_data  = cfg;
        @(negedge ap_clk);
        config_valid = 1'b0;

        pushed = 0;
        pause  = 0;
        while (pushed < count) begin
            @(negedge ap_clk);
            engine_valid = 1'b0;
            if (pause > 0) begin
                pause = pause - 1;
            end else if (engine_full) begin
                if (bursty) begin
                    rnd   = $random(seed);
                    pause = int'(rnd[3:0]);
                end
            end else begin
                rnd          = $random(seed);
                engine_index = rnd[`RW_INDEX_W-1:0];
                rnd          = $random(seed);
                engine_value = rnd;
                engine_valid = 1'b1;
                exp_req.push_back(expected_request(engine_index, engine_value, cfg));
                pushed = pushed + 1;
            end
        end
        @(negedge ap_clk);
        engine_valid = 1'b0;

        while (!done) begin
            @(negedge ap_clk);
        end
        check_value({name, ": requests left"}, CHECK_W'(0), CHECK_W'(exp_req.size()));
        check_value({name, ": reads"}, CHECK_W'(expected_reads),
                    CHECK_W'(reads_seen - reads_before));
        check_value({name, ": responses"}, CHECK_W'(expected_reads),
                    CHECK_W'(resps_seen - resps_before));

        // Held until the next start
        repeat (8) begin
            @(negedge ap_clk);
            check_value({name, ": done held"}, CHECK_W'(1), CHECK_W'(done));
        end
    endtask

    initial begin
        areset       = 1'b1;
        start        = 1'b0;
        config_valid = 1'b0;
        config_data  = '0;
        engine_valid = 1'b0;
        engine_index = '0;
        engine_value = '0;

        repeat (16) @(posedge ap_clk);
        @(negedge ap_clk);
        areset = 1'b0;
        repeat (2) @(negedge ap_clk);
        check_value("reset: outputs low", CHECK_W'(0),
                    CHECK_W'({config_request, mem_req_valid, engine_resp_valid, done,
                              engine_full}));

        run_test("read_run", 32'h1000_0000, 5'd2, READ_ITEMS, 1'b0, 32'h0, 1'b0);
        run_test("write_run", 32'h2000_0400, 5'd3, WRITE_ITEMS, 1'b1, 32'h5a5a_a5a5, 1'b0);
        run_test("backpressure_run", 32'h0004_0000, 5'd4, BURST_ITEMS, 1'b0, 32'hffff_0000,
                 1'b1);
        // New base, shift and count on a second start out of done
        run_test("new_config_run", 32'h8000_0010, 5'd7, RECONF_ITEMS, 1'b0, 32'h0, 1'b1);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ap_clk);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire
